//--- rtl/lstm_settings.svh
`ifndef LSTM_SETTINGS_SVH
`define LSTM_SETTINGS_SVH

// datapath widths
`define LSTM_DATA_W     8
`define LSTM_ACC_W      32
`define LSTM_VEC_N      4
`define LSTM_LANES      3

// schedule, counted from the cycle after load
`define LSTM_STEPS      19
`define LSTM_STEP_GATES 16
`define LSTM_STEP_PRE_Z 4
`define LSTM_STEP_PRE_I 8
`define LSTM_STEP_ACT1  12
`define LSTM_STEP_CELL  13
`define LSTM_STEP_PRE_O 16
`define LSTM_STEP_ACT2  17
`define LSTM_STEP_OUT   18

// rescale after a product of two activations
`define LSTM_Q_SHIFT    7

`endif

//--- rtl/lstm_pkg.sv
`include "lstm_settings.svh"

package lstm_pkg;

    // one signed sample or weight
    typedef logic signed [`LSTM_DATA_W-1:0] data_t;

    // element 0 sits in the low byte
    typedef data_t [`LSTM_VEC_N-1:0] vec_t;

    typedef enum logic [1:0] {
        GATE_Z = 2'd0,
        GATE_I = 2'd1,
        GATE_F = 2'd2,
        GATE_O = 2'd3
    } gate_e;

    // one weight row per gate, indexed by gate_e
    typedef vec_t [3:0] gate_mat_t;

    typedef logic signed [`LSTM_ACC_W-1:0] acc_t;

    typedef logic [4:0] step_t;

    // p_i in the low byte
    typedef struct packed {
        data_t p_o;
        data_t p_f;
        data_t p_i;
    } peep_t;

endpackage

//--- rtl/lstm_seq_if.sv
`timescale 1ns/100ps

interface lstm_seq_if import lstm_pkg::*; ();

    logic  busy;
    logic  load;
    step_t step;
    gate_e gate;

    modport ctrl (
        output busy,
        output load,
        output step,
        output gate
    );

    modport dp (
        input busy,
        input load,
        input step,
        input gate
    );

    // output stage only needs to know where the run is
    modport res (
        input busy,
        input step
    );

endinterface

//--- rtl/lstm_sequencer.sv
`timescale 1ns/100ps
`include "lstm_settings.svh"

module lstm_sequencer import lstm_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    lstm_seq_if.ctrl  seq
);

    logic  busy_q;
    step_t step_q;
    logic  last_step;

    assign last_step = (step_q == step_t'(`LSTM_STEPS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            step_q <= '0;
        end else if (!busy_q) begin
            // start is only looked at while idle
            busy_q <= start;
            step_q <= '0;
        end else if (last_step) begin
            busy_q <= 1'b0;
            step_q <= '0;
        end else begin
            step_q <= step_q + step_t'(1);
        end
    end

    assign seq.busy = busy_q;
    assign seq.step = step_q;
    assign seq.load = start && !busy_q;

    // four steps per gate, z first
    assign seq.gate = gate_e'(step_q[3:2]);

    a_step_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy_q |-> step_q <= step_t'(`LSTM_STEPS - 1)
    );

endmodule

//--- rtl/gate_dot_unit.sv
`timescale 1ns/100ps
`include "lstm_settings.svh"

module gate_dot_unit import lstm_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    lstm_seq_if.dp    seq,
    input  vec_t      vec,
    input  gate_mat_t mat,
    output acc_t      sum
);

    vec_t       vec_q;
    gate_mat_t  mat_q;
    vec_t       row;
    acc_t       prod [4];
    acc_t       sum_q;
    logic       run;

    function automatic acc_t mul(data_t a, data_t b);
        return acc_t'(a) * acc_t'(b);
    endfunction

    assign row = mat_q[seq.gate];
    assign run = seq.busy && (seq.step < step_t'(`LSTM_STEP_GATES));

    always_ff @(posedge clk) begin
        if (seq.load) begin
            vec_q <= vec;
            mat_q <= mat;
        end
    end

    // two products, then pairwise adds; prod[0] and prod[2] carry the halves
    always_ff @(posedge clk) begin
        if (run) begin
            case (seq.step[1:0])
                2'd0: begin
                    prod[0] <= mul(vec_q[0], row[0]);
                    prod[1] <= mul(vec_q[1], row[1]);
                end
                2'd1: begin
                    prod[0] <= prod[0] + prod[1];
                    prod[2] <= mul(vec_q[2], row[2]);
                    prod[3] <= mul(vec_q[3], row[3]);
                end
                2'd2: begin
                    prod[2] <= prod[2] + prod[3];
                end
                default: ;
            endcase
        end
    end

    // held for the four steps of the next gate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q <= '0;
        end else if (run && seq.step[1:0] == 2'd3) begin
            sum_q <= prod[0] + prod[2];
        end
    end

    assign sum = sum_q;

endmodule

//--- rtl/cell_state_unit.sv
`timescale 1ns/100ps
`include "lstm_settings.svh"

module cell_state_unit import lstm_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    lstm_seq_if.dp                 seq,
    input  peep_t                  peep,
    input  acc_t                   sum_x,
    input  acc_t                   sum_y,
    output logic [`LSTM_LANES-1:0] act_req,
    output data_t                  act_arg [`LSTM_LANES],
    input  data_t                  act_res [`LSTM_LANES],
    output acc_t                   c_next
);

    peep_t peep_q;
    acc_t  pre_z;
    acc_t  pre_i;
    acc_t  pre_o;
    acc_t  pre_g;
    acc_t  pre_f;
    data_t a_z;
    data_t a_i;
    data_t a_f;
    acc_t  c_q;
    acc_t  c_upd;

    function automatic acc_t peep_mul(data_t p, acc_t c);
        return acc_t'(p) * c;
    endfunction

    // saturate, else sign plus bits 14..8
    function automatic data_t quantise(acc_t v);
        data_t q;
        if (v > 32767) begin
            q = data_t'(127);
        end else if (v < -32768) begin
            q = data_t'(-128);
        end else begin
            q = {v[31], v[14:8]};
        end
        return q;
    endfunction

    assign pre_g = sum_x + sum_y;

    // f sums are still held in step 12, old c
    assign pre_f = pre_g + peep_mul(peep_q.p_f, c_q);

    assign c_upd = (acc_t'(a_z) * acc_t'(a_i) + c_q * acc_t'(a_f)) >>> `LSTM_Q_SHIFT;

    always_ff @(posedge clk) begin
        if (seq.load) begin
            peep_q <= peep;
        end
        if (seq.busy) begin
            case (seq.step)
                step_t'(`LSTM_STEP_PRE_Z): pre_z <= pre_g;
                step_t'(`LSTM_STEP_PRE_I): pre_i <= pre_g + peep_mul(peep_q.p_i, c_q);
                step_t'(`LSTM_STEP_ACT1): begin
                    a_z <= act_res[0];
                    a_i <= act_res[1];
                    a_f <= act_res[2];
                end
                // c was updated in step 13, so this is the new c
                step_t'(`LSTM_STEP_PRE_O): pre_o <= pre_g + peep_mul(peep_q.p_o, c_q);
                default: ;
            endcase
        end
    end

    // cell state carries over from run to run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_q <= '0;
        end else if (seq.busy && seq.step == step_t'(`LSTM_STEP_CELL)) begin
            c_q <= c_upd;
        end
    end

    always_comb begin
        act_req = '0;
        act_arg = '{default: '0};
        if (seq.busy && seq.step == step_t'(`LSTM_STEP_ACT1)) begin
            act_req    = '1;
            act_arg[0] = quantise(pre_z);
            act_arg[1] = quantise(pre_i);
            act_arg[2] = quantise(pre_f);
        end else if (seq.busy && seq.step == step_t'(`LSTM_STEP_ACT2)) begin
            // lane 0 for o, lane 1 for h
            act_req[0] = 1'b1;
            act_req[1] = 1'b1;
            act_arg[0] = quantise(pre_o);
            act_arg[1] = quantise(c_q);
        end
    end

    assign c_next = c_q;

    a_req_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !seq.busy |-> act_req == '0
    );

endmodule

//--- rtl/lstm_output_stage.sv
`timescale 1ns/100ps
`include "lstm_settings.svh"

module lstm_output_stage import lstm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    lstm_seq_if.res seq,
    input  data_t   a_o,
    input  data_t   a_h,
    output data_t   y,
    output logic    valid
);

    data_t a_o_q;
    data_t a_h_q;
    acc_t  y_full;
    data_t y_q;
    logic  valid_q;
    logic  out_step;

    assign out_step = seq.busy && seq.step == step_t'(`LSTM_STEP_OUT);

    // lane responses of step 17
    always_ff @(posedge clk) begin
        if (seq.busy && seq.step == step_t'(`LSTM_STEP_ACT2)) begin
            a_o_q <= a_o;
            a_h_q <= a_h;
        end
    end

    assign y_full = (acc_t'(a_h_q) * acc_t'(a_o_q)) >>> `LSTM_Q_SHIFT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_q     <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= out_step;
            if (out_step) begin
                y_q <= y_full[`LSTM_DATA_W-1:0];
            end
        end
    end

    assign y     = y_q;
    assign valid = valid_q;

    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_q |=> !valid_q
    );

endmodule

//--- rtl/lstm_cell.sv
`timescale 1ns/100ps
`include "lstm_settings.svh"

module lstm_cell import lstm_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  vec_t                   x,
    input  vec_t                   y_prev,
    input  gate_mat_t              w_x,
    input  gate_mat_t              w_y,
    input  peep_t                  peep,
    output logic [`LSTM_LANES-1:0] act_req,
    output data_t                  act_arg [`LSTM_LANES],
    input  data_t                  act_res [`LSTM_LANES],
    output data_t                  y,
    output logic                   valid
);

    acc_t sum_x;
    acc_t sum_y;

    lstm_seq_if seq_if ();

    lstm_sequencer seq_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .seq   (seq_if.ctrl)
    );

    // input lane
    gate_dot_unit dot_x_i (
        .clk   (clk),
        .rst_n (rst_n),
        .seq   (seq_if.dp),
        .vec   (x),
        .mat   (w_x),
        .sum   (sum_x)
    );

    // recurrent lane
    gate_dot_unit dot_y_i (
        .clk   (clk),
        .rst_n (rst_n),
        .seq   (seq_if.dp),
        .vec   (y_prev),
        .mat   (w_y),
        .sum   (sum_y)
    );

    cell_state_unit cell_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .seq     (seq_if.dp),
        .peep    (peep),
        .sum_x   (sum_x),
        .sum_y   (sum_y),
        .act_req (act_req),
        .act_arg (act_arg),
        .act_res (act_res),
        .c_next  ()
    );

    // o on lane 0, h on lane 1 in step 17
    lstm_output_stage out_i (
        .clk   (clk),
        .rst_n (rst_n),
        .seq   (seq_if.res),
        .a_o   (act_res[0]),
        .a_h   (act_res[1]),
        .y     (y),
        .valid (valid)
    );

endmodule

//--- tb/tb_lstm_cell.sv
`timescale 1ns/100ps
`include "lstm_settings.svh"

module tb_lstm_cell import lstm_pkg::*; ();

    localparam int    CLK_PERIOD = 10;
    localparam int    MAX_VEC    = 32;
    localparam string VEC_FILE   = "tb/lstm_vectors.txt";

    // cycles counted from the start cycle
    localparam int REQ1_CYCLE  = `LSTM_STEP_ACT1 + 1;
    localparam int REQ2_CYCLE  = `LSTM_STEP_ACT2 + 1;
    localparam int VALID_CYCLE = `LSTM_STEPS + 1;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    vec_t                   x;
    vec_t                   y_prev;
    gate_mat_t              w_x;
    gate_mat_t              w_y;
    peep_t                  peep;
    logic [`LSTM_LANES-1:0] act_req;
    data_t                  act_arg [`LSTM_LANES];
    data_t                  act_res [`LSTM_LANES];
    data_t                  y;
    logic                   valid;

    // one entry per vector line; args are z, i, f, o, h
    vec_t      v_x      [MAX_VEC];
    vec_t      v_y_prev [MAX_VEC];
    gate_mat_t v_w_x    [MAX_VEC];
    gate_mat_t v_w_y    [MAX_VEC];
    peep_t     v_peep   [MAX_VEC];
    data_t     v_arg    [MAX_VEC][5];
    data_t     v_y      [MAX_VEC];
    int        n_vec = 0;
    integer    seed;

    lstm_cell dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .x       (x),
        .y_prev  (y_prev),
        .w_x     (w_x),
        .w_y     (w_y),
        .peep    (peep),
        .act_req (act_req),
        .act_arg (act_arg),
        .act_res (act_res),
        .y       (y),
        .valid   (valid)
    );

    // lookup model, arg/2 + 64 on each requesting lane
    always_comb begin
        for (int k = 0; k < `LSTM_LANES; k++) begin
            act_res[k] = act_req[k] ? data_t'((act_arg[k] >>> 1) + 64) : data_t'(0);
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_failed();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_arg(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("ERR %0t %s: expected %0d, got %0d", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_y(data_t exp, data_t act);
        if (act !== exp) begin
            $display("ERR %0t y: expected %0d, got %0d", $time, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_req(logic [`LSTM_LANES-1:0] exp, logic [`LSTM_LANES-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t act_req: expected %b, got %b", $time, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_valid(logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %0t valid: expected %b, got %b", $time, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_idle();
        check_req('0, act_req);
        check_valid(1'b0, valid);
    endtask

    task automatic load_vectors();
        int           fd;
        int           cnt;
        string        line;
        logic [31:0]  f_x;
        logic [31:0]  f_yp;
        logic [127:0] f_wx;
        logic [127:0] f_wy;
        logic [23:0]  f_peep;
        logic [7:0]   f_az;
        logic [7:0]   f_ai;
        logic [7:0]   f_af;
        logic [7:0]   f_ao;
        logic [7:0]   f_ah;
        logic [7:0]   f_y;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", VEC_FILE);
            stop_failed();
        end
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_x, f_yp, f_wx, f_wy,
                          f_peep, f_az, f_ai, f_af, f_ao, f_ah, f_y);
            if (cnt != 11) begin
                $display("malformed line in %s: %s", VEC_FILE, line);
                stop_failed();
            end
            if (n_vec >= MAX_VEC) begin
                $display("too many vectors in %s, at most %0d fit", VEC_FILE, MAX_VEC);
                stop_failed();
            end
            v_x[n_vec]      = f_x;
            v_y_prev[n_vec] = f_yp;
            v_w_x[n_vec]    = f_wx;
            v_w_y[n_vec]    = f_wy;
            v_peep[n_vec]   = f_peep;
            v_arg[n_vec][0] = f_az;
            v_arg[n_vec][1] = f_ai;
            v_arg[n_vec][2] = f_af;
            v_arg[n_vec][3] = f_ao;
            v_arg[n_vec][4] = f_ah;
            v_y[n_vec]      = f_y;
            n_vec++;
        end
        $fclose(fd);
        if (n_vec == 0) begin
            $display("no vectors found in %s", VEC_FILE);
            stop_failed();
        end
    endtask

    task automatic run_vector(int idx);
        int glitch_at;
        glitch_at = 0;
        // odd vectors see a stray start while busy
        if (idx % 2 == 1) begin
            glitch_at = 3 + {$random(seed)} % 15;
        end
        @(posedge clk);
        start  <= 1'b1;
        x      <= v_x[idx];
        y_prev <= v_y_prev[idx];
        w_x    <= v_w_x[idx];
        w_y    <= v_w_y[idx];
        peep   <= v_peep[idx];
        for (int n = 1; n <= VALID_CYCLE; n++) begin
            @(posedge clk);
            if (n == 1 || n == glitch_at + 1) begin
                start <= 1'b0;
            end
            // these inputs must not be captured
            if (n == glitch_at) begin
                start  <= 1'b1;
                x      <= ~v_x[idx];
                y_prev <= ~v_y_prev[idx];
            end
            @(negedge clk);
            if (n == REQ1_CYCLE) begin
                check_req(3'b111, act_req);
                check_arg("act_arg[0] z", v_arg[idx][0], act_arg[0]);
                check_arg("act_arg[1] i", v_arg[idx][1], act_arg[1]);
                check_arg("act_arg[2] f", v_arg[idx][2], act_arg[2]);
            end else if (n == REQ2_CYCLE) begin
                check_req(3'b011, act_req);
                check_arg("act_arg[0] o", v_arg[idx][3], act_arg[0]);
                check_arg("act_arg[1] h", v_arg[idx][4], act_arg[1]);
            end else begin
                check_req('0, act_req);
            end
            check_valid(n == VALID_CYCLE, valid);
        end
        check_y(v_y[idx], y);
        // valid is a single-cycle pulse
        @(negedge clk);
        check_idle();
    endtask

    initial begin
        int gap;
        seed   = 43;
        rst_n  = 1'b0;
        start  = 1'b0;
        x      = '0;
        y_prev = '0;
        w_x    = '0;
        w_y    = '0;
        peep   = '0;
        load_vectors();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // quiet until the first start
        repeat (3) begin
            @(negedge clk);
            check_idle();
            check_y(data_t'(0), y);
        end
        // no reset between vectors, c carries over
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
            gap = {$random(seed)} % 4;
            repeat (gap) begin
                @(negedge clk);
                check_idle();
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // roughly 40 cycles per vector plus reset and idle time
    initial begin
        int limit;
        wait (n_vec > 0);
        limit = n_vec * 40 + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        stop_failed();
    end

endmodule

//--- tb/lstm_vectors.txt
# x y_prev w_x w_y peep, then expected args z i f o h, then expected y (all hex)
# w_x and w_y hold rows o f i z from the left; element 0 and p_i sit in the low byte
281e140a fd000005 9c9c9c9c7f0000000000003264646464 0a00000a000000000a00000000000014 040302 27 01 13 d9 00 16
7f7f7f7f 00000000 0101010180808080000000007f7f7f7f 00000000000000000000000000000000 fe0a64 7f 10 80 01 00 20
7f7f7f7f 80808080 000000007f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f000000000000000000000000 010000 7f 7f 7f 80 00 00
04030201 00000000 ffffffff0a0a0a0a0000000064646464 00000000000000000000000000000000 ce647f 03 61 4c d6 00 15
7f7f7f7f 00000000 000000007f7f7f7f7f7f7f7f7f7f7f7f 00000000000000000000000000000000 640000 7f 7f 7f 7f 01 3f
28e214f6 03030303 00000a0000ce0000000000ff01010101 0000000000000080000000009c9c9c9c 05ecfd fb fc ea 04 00 21

//--- vlog.f
+incdir+rtl
rtl/lstm_pkg.sv
rtl/lstm_seq_if.sv
rtl/lstm_sequencer.sv
rtl/gate_dot_unit.sv
rtl/cell_state_unit.sv
rtl/lstm_output_stage.sv
rtl/lstm_cell.sv
tb/tb_lstm_cell.sv

//--- Makefile
# Verilator build and run of the LSTM cell testbench

VERILATOR ?= verilator
TOP       ?= tb_lstm_cell
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
